// File: tb.f
+incdir+include
hw/bmu_bus_pkg.sv
hw/bmu_map_pkg.sv
hw/bmu_region_decode.sv
hw/bmu_bus_port.sv
hw/bmu_top.sv
verification/bmu_tb.sv

// File: Bender.yml
package:
  name: bmu

sources:
  # packages first, then the RTL bottom up
  - hw/bmu_bus_pkg.sv
  - hw/bmu_map_pkg.sv
  - hw/bmu_region_decode.sv
  - hw/bmu_bus_port.sv
  - hw/bmu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/bmu_tb.sv

// File: include/bmu_tb_vectors.svh
/*
 * bmu testbench stimulus table
 * one entry per transfer, with the expected slave target
 */
`ifndef BMU_TB_VECTORS_SVH
`define BMU_TB_VECTORS_SVH

typedef struct {
  string                name;
  int                   bus;        // 0 ibus, 1 dbus
  bit                   with_next;  // launch together with the next entry
  bit                   deny;
  bit                   slave_err;
  bmu_map_pkg::target_e exp_tgt;
  logic [31:0]          addr;
  logic [3:0]           prot;
  logic [1:0]           size;
  logic                 write;
  logic [31:0]          wdata;
} vec_t;

vec_t vectors[$];

task automatic add_vector(input string name, input int bus, input bit with_next,
                          input bit deny, input bit slave_err,
                          input bmu_map_pkg::target_e exp_tgt, input logic [31:0] addr,
                          input logic [3:0] prot, input logic [1:0] size,
                          input logic write, input logic [31:0] wdata);
  vectors.push_back('{name, bus, with_next, deny, slave_err, exp_tgt,
                      addr, prot, size, write, wdata});
endtask

// name, bus, with_next, deny, slave_err, expected target
//   then addr, prot, size, write, wdata
// iahbl window is addr[31:24] == 8'h2A with the fixed base and mask
task automatic load_vectors();
  add_vector("ifu_tcip", 0, 0, 0, 0, bmu_map_pkg::TGT_TCIP,
             32'hE000_1000, 4'h1, 2'd2, 1'b0, 32'h0);
  add_vector("ifu_iahbl_in", 0, 0, 0, 0, bmu_map_pkg::TGT_IAHBL,
             32'h2A00_0100, 4'h1, 2'd2, 1'b0, 32'h0);
  add_vector("ifu_iahbl_out", 0, 0, 0, 0, bmu_map_pkg::TGT_BIU,
             32'h2B00_0000, 4'h5, 2'd2, 1'b0, 32'h0);
  add_vector("lsu_tcip_wr", 1, 0, 0, 0, bmu_map_pkg::TGT_TCIP,
             32'hE000_0200, 4'h3, 2'd2, 1'b1, 32'hCAFE_0001);
  add_vector("lsu_iahbl_rd", 1, 0, 0, 0, bmu_map_pkg::TGT_IAHBL,
             32'h2AFF_FFF0, 4'h3, 2'd1, 1'b0, 32'h0);
  add_vector("lsu_biu_wr", 1, 0, 0, 0, bmu_map_pkg::TGT_BIU,
             32'h8000_0010, 4'hB, 2'd0, 1'b1, 32'h0000_00A5);
  add_vector("ifu_deny", 0, 0, 1, 0, bmu_map_pkg::TGT_DENY,
             32'h0000_0080, 4'h1, 2'd2, 1'b0, 32'h0);
  add_vector("lsu_deny", 1, 0, 1, 0, bmu_map_pkg::TGT_DENY,
             32'hE000_0000, 4'h3, 2'd2, 1'b1, 32'h1234_5678);
  add_vector("ifu_slv_err", 0, 0, 0, 1, bmu_map_pkg::TGT_IAHBL,
             32'h2A00_0000, 4'h1, 2'd2, 1'b0, 32'h0);
  add_vector("lsu_slv_err", 1, 0, 0, 1, bmu_map_pkg::TGT_BIU,
             32'h4000_0000, 4'h3, 2'd2, 1'b1, 32'h0BAD_0BAD);
  add_vector("conc_ifu_tcip", 0, 1, 0, 0, bmu_map_pkg::TGT_TCIP,
             32'hE000_0040, 4'h1, 2'd2, 1'b0, 32'h0);
  add_vector("conc_lsu_iahbl", 1, 0, 0, 0, bmu_map_pkg::TGT_IAHBL,
             32'h2A00_0800, 4'h3, 2'd2, 1'b0, 32'h0);
  add_vector("conc_ifu_iahbl", 0, 1, 0, 0, bmu_map_pkg::TGT_IAHBL,
             32'h2A40_0010, 4'h1, 2'd2, 1'b0, 32'h0);
  add_vector("conc_lsu_biu", 1, 0, 0, 0, bmu_map_pkg::TGT_BIU,
             32'h9000_0000, 4'h3, 2'd2, 1'b1, 32'h5A5A_0F0F);
endtask

`endif

// File: verification/bmu_tb.sv
/*
 * bus management unit testbench
 * table driven transfers on both buses against six slave models
 */
`timescale 1ns/10ps

module bmu_tb;

  localparam int NUM_SLAVES   = 6;
  localparam int RESET_CYCLES = 10;
  localparam logic [bmu_map_pkg::REGION_W-1:0] IAHBL_BASE = 12'h2A0;
  localparam logic [bmu_map_pkg::REGION_W-1:0] IAHBL_MASK = 12'hFF0;
  // slave order: tcip, iahbl, biu on ibus, then the same on dbus
  localparam logic [31:0] SLAVE_TAG [NUM_SLAVES] = '{
    32'h1111_0001, 32'h2222_0002, 32'h3333_0003,
    32'h4444_0004, 32'h5555_0005, 32'h6666_0006
  };

  logic                   forever_cpuclk;
  logic                   rst_n;
  bmu_bus_pkg::ibus_req_t ifu_req;
  bmu_bus_pkg::bus_rsp_t  ifu_rsp;
  bmu_bus_pkg::dbus_req_t lsu_req;
  bmu_bus_pkg::bus_rsp_t  lsu_rsp;
  logic                   pmp_ibus_acc_deny;
  logic                   pmp_dbus_acc_deny;
  bmu_bus_pkg::ibus_req_t ibus_fwd [3];
  bmu_bus_pkg::dbus_req_t dbus_fwd [3];
  bmu_bus_pkg::bus_rsp_t  slv_rsp [NUM_SLAVES];
  logic [NUM_SLAVES-1:0]  slv_req;
  logic [31:0]            slv_addr [NUM_SLAVES];

  // slave model state
  int          slv_phase [NUM_SLAVES];
  int          slv_wait [NUM_SLAVES];
  int          slv_cnt [NUM_SLAVES];
  logic        slv_fail [NUM_SLAVES];
  logic        slv_err [NUM_SLAVES];
  logic [31:0] slv_addr_q [NUM_SLAVES];
  logic [31:0] junk_data [NUM_SLAVES];
  logic [3:0]  junk_bits [NUM_SLAVES];

  int checks = 0;
  int errors = 0;
  int cycle_cnt;

  `include "bmu_tb_vectors.svh"

  bmu_top DUT (
    .forever_cpuclk    (forever_cpuclk),
    .rst_n             (rst_n),
    .ifu_req           (ifu_req),
    .ifu_rsp           (ifu_rsp),
    .lsu_req           (lsu_req),
    .lsu_rsp           (lsu_rsp),
    .pmp_ibus_acc_deny (pmp_ibus_acc_deny),
    .pmp_dbus_acc_deny (pmp_dbus_acc_deny),
    .pad_iahbl_base    (IAHBL_BASE),
    .pad_iahbl_mask    (IAHBL_MASK),
    .tcip_ibus_req     (ibus_fwd[0]),
    .tcip_ibus_rsp     (slv_rsp[0]),
    .iahbl_ibus_req    (ibus_fwd[1]),
    .iahbl_ibus_rsp    (slv_rsp[1]),
    .biu_ibus_req      (ibus_fwd[2]),
    .biu_ibus_rsp      (slv_rsp[2]),
    .tcip_dbus_req     (dbus_fwd[0]),
    .tcip_dbus_rsp     (slv_rsp[3]),
    .iahbl_dbus_req    (dbus_fwd[1]),
    .iahbl_dbus_rsp    (slv_rsp[4]),
    .biu_dbus_req      (dbus_fwd[2]),
    .biu_dbus_rsp      (slv_rsp[5])
  );

  initial begin
    forever_cpuclk = 1'b0;
    forever #50 forever_cpuclk = ~forever_cpuclk;
  end

  always_comb begin
    for (int k = 0; k < 3; k++) begin
      slv_req[k]      = ibus_fwd[k].req;
      slv_req[k + 3]  = dbus_fwd[k].req;
      slv_addr[k]     = ibus_fwd[k].addr;
      slv_addr[k + 3] = dbus_fwd[k].addr;
    end
  end

  //==================================================
  // slave models
  //==================================================
  always_comb begin
    for (int k = 0; k < NUM_SLAVES; k++) begin
      slv_rsp[k] = '0;
      if (slv_phase[k] == 0) begin
        // idle, junk except the real grant to a waiting request
        slv_rsp[k].grnt        = slv_req[k] ? (slv_wait[k] == 0) : junk_bits[k][0];
        slv_rsp[k].data_vld    = junk_bits[k][1];
        slv_rsp[k].trans_cmplt = junk_bits[k][2];
        slv_rsp[k].acc_err     = junk_bits[k][3];
        slv_rsp[k].data        = junk_data[k];
      end else if (slv_cnt[k] == 0) begin
        slv_rsp[k].data_vld    = 1'b1;
        slv_rsp[k].trans_cmplt = 1'b1;
        slv_rsp[k].acc_err     = slv_err[k];
        slv_rsp[k].data        = slv_addr_q[k] ^ SLAVE_TAG[k];
      end
    end
  end

  initial begin : slave_models
    int unsigned           seed_val;
    int                    k;
    logic [NUM_SLAVES-1:0] waiting;
    logic [NUM_SLAVES-1:0] granted;
    logic [NUM_SLAVES-1:0] done;
    logic [31:0]           addr_seen [NUM_SLAVES];
    seed_val = $urandom(15);
    for (k = 0; k < NUM_SLAVES; k++) begin
      slv_phase[k]  = 0;
      slv_wait[k]   = $urandom_range(2, 0);
      slv_cnt[k]    = 0;
      slv_fail[k]   = 1'b0;
      slv_err[k]    = 1'b0;
      slv_addr_q[k] = '0;
      junk_data[k]  = $urandom;
      junk_bits[k]  = $urandom_range(15, 0);
    end
    forever begin
      @(negedge forever_cpuclk);
      for (k = 0; k < NUM_SLAVES; k++) begin
        waiting[k]   = slv_req[k] && (slv_phase[k] == 0);
        granted[k]   = waiting[k] && (slv_wait[k] == 0);
        done[k]      = (slv_phase[k] == 1) && (slv_cnt[k] == 0);
        addr_seen[k] = slv_addr[k];
      end
      @(posedge forever_cpuclk);
      #5;
      for (k = 0; k < NUM_SLAVES; k++) begin
        junk_data[k] = $urandom;
        junk_bits[k] = $urandom_range(15, 0);
        if (granted[k]) begin
          // completion 1 to 3 cycles after the grant
          slv_phase[k]  = 1;
          slv_cnt[k]    = $urandom_range(2, 0);
          slv_addr_q[k] = addr_seen[k];
          slv_err[k]    = slv_fail[k];
        end else if (done[k]) begin
          slv_phase[k] = 0;
          slv_wait[k]  = $urandom_range(2, 0);
        end else if (slv_phase[k] == 1) begin
          slv_cnt[k]--;
        end else if (waiting[k] && slv_wait[k] > 0) begin
          slv_wait[k]--;
        end
      end
    end
  end

  //==================================================
  // checks and transfers
  //==================================================
  task automatic check_value(input string name, input string what,
                             input logic [71:0] exp, input logic [71:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("** Error: %s: %s expected %0h, actual %0h", name, what, exp, act);
    end
  endtask

  function automatic bmu_bus_pkg::ibus_req_t ibus_request(input vec_t v);
    bmu_bus_pkg::ibus_req_t r;
    r.req  = 1'b1;
    r.addr = v.addr;
    r.prot = v.prot;
    return r;
  endfunction

  function automatic bmu_bus_pkg::dbus_req_t dbus_request(input vec_t v);
    bmu_bus_pkg::dbus_req_t r;
    r.req   = 1'b1;
    r.addr  = v.addr;
    r.prot  = v.prot;
    r.size  = v.size;
    r.write = v.write;
    r.wdata = v.wdata;
    return r;
  endfunction

  function automatic bmu_bus_pkg::bus_rsp_t master_rsp(input int bus);
    return (bus == 0) ? ifu_rsp : lsu_rsp;
  endfunction

  task automatic drive_request(input vec_t v, input bit on);
    if (v.bus == 0) begin
      ifu_req           = on ? ibus_request(v) : '0;
      pmp_ibus_acc_deny = on & v.deny;
    end else begin
      lsu_req           = on ? dbus_request(v) : '0;
      pmp_dbus_acc_deny = on & v.deny;
    end
  endtask

  // only the decoded slave of this bus may see req, with the fields intact
  task automatic check_forwarding(input vec_t v);
    int          k;
    logic [71:0] act;
    logic [71:0] exp;
    for (k = 0; k < 3; k++) begin
      if (!v.deny && k == int'(v.exp_tgt) - 1) begin
        if (v.bus == 0) begin
          act = ibus_fwd[k];
          exp = ibus_request(v);
        end else begin
          act = dbus_fwd[k];
          exp = dbus_request(v);
        end
        check_value(v.name, "forwarded request", exp, act);
      end else begin
        check_value(v.name, $sformatf("req on slave %0d", v.bus * 3 + k), 0,
                    slv_req[v.bus * 3 + k]);
      end
    end
  endtask

  task automatic run_transfer(input int idx);
    vec_t                  v;
    bmu_bus_pkg::bus_rsp_t rsp;
    int                    cycles;
    int                    slot;
    int                    k;
    v    = vectors[idx];
    slot = v.bus * 3 + int'(v.exp_tgt) - 1;
    for (k = 0; k < 3; k++) begin
      slv_fail[v.bus * 3 + k] = v.slave_err;
    end
    drive_request(v, 1'b1);
    cycles = 0;
    do begin
      @(negedge forever_cpuclk);
      check_forwarding(v);
      rsp = master_rsp(v.bus);
      if (v.deny && cycles == 0) begin
        check_value(v.name, "grnt in request cycle", 1, rsp.grnt);
      end
      cycles++;
    end while (!rsp.grnt);
    @(posedge forever_cpuclk);
    #5;
    drive_request(v, 1'b0);
    cycles = 0;
    do begin
      @(negedge forever_cpuclk);
      rsp = master_rsp(v.bus);
      cycles++;
    end while (!rsp.trans_cmplt);
    if (v.deny) begin
      check_value(v.name, "cycles to deny completion", 1, cycles);
      check_value(v.name, "data", 0, rsp.data);
    end else begin
      check_value(v.name, "data", v.addr ^ SLAVE_TAG[slot], rsp.data);
    end
    check_value(v.name, "data_vld", !v.deny, rsp.data_vld);
    check_value(v.name, "acc_err", v.deny | v.slave_err, rsp.acc_err);
    // completion lasts a single cycle, then the port is idle again
    @(negedge forever_cpuclk);
    rsp = master_rsp(v.bus);
    check_value(v.name, "vld/cmplt/err after completion", 0,
                {rsp.data_vld, rsp.trans_cmplt, rsp.acc_err});
    @(posedge forever_cpuclk);
    #5;
  endtask

  initial begin : watchdog
    cycle_cnt = 0;
    forever begin
      @(posedge forever_cpuclk);
      cycle_cnt++;
      if (cycle_cnt >= vectors.size() * 12 + RESET_CYCLES + 50) begin
        $display("timeout: transfers still pending after %0d cycles", cycle_cnt);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Simulation FAILED");
        $finish;
      end
    end
  end

  initial begin : main
    int i;
    rst_n             = 1'b0;
    ifu_req           = '0;
    lsu_req           = '0;
    pmp_ibus_acc_deny = 1'b0;
    pmp_dbus_acc_deny = 1'b0;
    load_vectors();
    repeat (RESET_CYCLES) @(posedge forever_cpuclk);
    #5;
    rst_n = 1'b1;
    @(negedge forever_cpuclk);
    check_value("reset_idle", "slave req bits", 0, slv_req);
    check_value("reset_idle", "ifu vld/cmplt/err", 0,
                {ifu_rsp.data_vld, ifu_rsp.trans_cmplt, ifu_rsp.acc_err});
    check_value("reset_idle", "lsu vld/cmplt/err", 0,
                {lsu_rsp.data_vld, lsu_rsp.trans_cmplt, lsu_rsp.acc_err});
    @(posedge forever_cpuclk);
    #5;
    i = 0;
    while (i < vectors.size()) begin
      if (vectors[i].with_next && i + 1 < vectors.size()) begin
        fork
          run_transfer(i);
          run_transfer(i + 1);
        join
        i += 2;
      end else begin
        run_transfer(i);
        i += 1;
      end
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: hw/bmu_top.sv
/*
 * bus management unit top
 * one bus port for instruction fetch, one for load/store, each
 * routed to the tcip, iahbl and biu slave paths
 */
`timescale 1ns/10ps

module bmu_top (
  input  logic                             forever_cpuclk,
  input  logic                             rst_n,
  // masters
  input  bmu_bus_pkg::ibus_req_t           ifu_req,
  output bmu_bus_pkg::bus_rsp_t            ifu_rsp,
  input  bmu_bus_pkg::dbus_req_t           lsu_req,
  output bmu_bus_pkg::bus_rsp_t            lsu_rsp,
  // protection and address window pins
  input  logic                             pmp_ibus_acc_deny,
  input  logic                             pmp_dbus_acc_deny,
  input  logic [bmu_map_pkg::REGION_W-1:0] pad_iahbl_base,
  input  logic [bmu_map_pkg::REGION_W-1:0] pad_iahbl_mask,
  // instruction bus slaves
  output bmu_bus_pkg::ibus_req_t           tcip_ibus_req,
  input  bmu_bus_pkg::bus_rsp_t            tcip_ibus_rsp,
  output bmu_bus_pkg::ibus_req_t           iahbl_ibus_req,
  input  bmu_bus_pkg::bus_rsp_t            iahbl_ibus_rsp,
  output bmu_bus_pkg::ibus_req_t           biu_ibus_req,
  input  bmu_bus_pkg::bus_rsp_t            biu_ibus_rsp,
  // data bus slaves
  output bmu_bus_pkg::dbus_req_t           tcip_dbus_req,
  input  bmu_bus_pkg::bus_rsp_t            tcip_dbus_rsp,
  output bmu_bus_pkg::dbus_req_t           iahbl_dbus_req,
  input  bmu_bus_pkg::bus_rsp_t            iahbl_dbus_rsp,
  output bmu_bus_pkg::dbus_req_t           biu_dbus_req,
  input  bmu_bus_pkg::bus_rsp_t            biu_dbus_rsp
);

  //==================================================
  // instruction fetch port
  //==================================================
  bmu_bus_port #(
    .req_t (bmu_bus_pkg::ibus_req_t)
  ) x_ibus_port (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .iahbl_base     (pad_iahbl_base),
    .iahbl_mask     (pad_iahbl_mask),
    .acc_deny       (pmp_ibus_acc_deny),
    .mst_req        (ifu_req),
    .mst_rsp        (ifu_rsp),
    .tcip_req       (tcip_ibus_req),
    .iahbl_req      (iahbl_ibus_req),
    .biu_req        (biu_ibus_req),
    .tcip_rsp       (tcip_ibus_rsp),
    .iahbl_rsp      (iahbl_ibus_rsp),
    .biu_rsp        (biu_ibus_rsp)
  );

  //==================================================
  // load/store port
  //==================================================
  // runs independently of the fetch port
  bmu_bus_port #(
    .req_t (bmu_bus_pkg::dbus_req_t)
  ) x_dbus_port (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .iahbl_base     (pad_iahbl_base),
    .iahbl_mask     (pad_iahbl_mask),
    .acc_deny       (pmp_dbus_acc_deny),
    .mst_req        (lsu_req),
    .mst_rsp        (lsu_rsp),
    .tcip_req       (tcip_dbus_req),
    .iahbl_req      (iahbl_dbus_req),
    .biu_req        (biu_dbus_req),
    .tcip_rsp       (tcip_dbus_rsp),
    .iahbl_rsp      (iahbl_dbus_rsp),
    .biu_rsp        (biu_dbus_rsp)
  );

endmodule

// File: hw/bmu_bus_port.sv
/*
 * bmu bus port
 * routes one master bus to tcip, iahbl or biu, turns a pmp deny into
 * a local error completion and returns the owning slave's response
 */
`timescale 1ns/10ps

module bmu_bus_port #(
  parameter type req_t = bmu_bus_pkg::ibus_req_t
) (
  input  logic                             forever_cpuclk,
  input  logic                             rst_n,
  input  logic [bmu_map_pkg::REGION_W-1:0] iahbl_base,
  input  logic [bmu_map_pkg::REGION_W-1:0] iahbl_mask,
  input  logic                             acc_deny,
  // master side
  input  req_t                             mst_req,
  output bmu_bus_pkg::bus_rsp_t            mst_rsp,
  // slave side
  output req_t                             tcip_req,
  output req_t                             iahbl_req,
  output req_t                             biu_req,
  input  bmu_bus_pkg::bus_rsp_t            tcip_rsp,
  input  bmu_bus_pkg::bus_rsp_t            iahbl_rsp,
  input  bmu_bus_pkg::bus_rsp_t            biu_rsp
);

  bmu_map_pkg::target_e  dec_tgt;
  bmu_map_pkg::target_e  cur_tgt;
  bmu_bus_pkg::bus_rsp_t sel_rsp;
  logic                  fwd_vld;
  logic                  slv_grnt;
  logic                  mst_grnt;
  logic                  cur_done;

  bmu_region_decode x_region_decode (
    .addr       (mst_req.addr),
    .iahbl_base (iahbl_base),
    .iahbl_mask (iahbl_mask),
    .target     (dec_tgt)
  );

  //==================================================
  // request forwarding
  //==================================================
  // a denied request never reaches a slave
  assign fwd_vld = mst_req.req & ~acc_deny;

  always_comb begin
    tcip_req      = mst_req;
    iahbl_req     = mst_req;
    biu_req       = mst_req;
    tcip_req.req  = fwd_vld & (dec_tgt == bmu_map_pkg::TGT_TCIP);
    iahbl_req.req = fwd_vld & (dec_tgt == bmu_map_pkg::TGT_IAHBL);
    biu_req.req   = fwd_vld & (dec_tgt == bmu_map_pkg::TGT_BIU);
  end

  // grant of the decoded slave only
  always_comb begin
    slv_grnt = 1'b0;
    case (dec_tgt)
      bmu_map_pkg::TGT_TCIP:  slv_grnt = tcip_rsp.grnt;
      bmu_map_pkg::TGT_IAHBL: slv_grnt = iahbl_rsp.grnt;
      bmu_map_pkg::TGT_BIU:   slv_grnt = biu_rsp.grnt;
      default:                slv_grnt = 1'b0;
    endcase
  end

  // deny is granted right away
  assign mst_grnt = mst_req.req & (acc_deny | slv_grnt);

  //==================================================
  // outstanding target
  //==================================================
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      cur_tgt <= bmu_map_pkg::TGT_NONE;
    end else if (mst_grnt) begin
      cur_tgt <= acc_deny ? bmu_map_pkg::TGT_DENY : dec_tgt;
    end else if (cur_done) begin
      cur_tgt <= bmu_map_pkg::TGT_NONE;
    end
  end

  //==================================================
  // response return
  //==================================================
  // idle slaves are ignored, whatever they drive
  always_comb begin
    sel_rsp = '0;
    case (cur_tgt)
      bmu_map_pkg::TGT_TCIP:  sel_rsp = tcip_rsp;
      bmu_map_pkg::TGT_IAHBL: sel_rsp = iahbl_rsp;
      bmu_map_pkg::TGT_BIU:   sel_rsp = biu_rsp;
      bmu_map_pkg::TGT_DENY: begin
        // local error completion, one cycle after the grant
        sel_rsp.trans_cmplt = 1'b1;
        sel_rsp.acc_err     = 1'b1;
      end
      default:                sel_rsp = '0;
    endcase
  end

  assign cur_done = sel_rsp.trans_cmplt;

  always_comb begin
    mst_rsp      = sel_rsp;
    mst_rsp.grnt = mst_grnt;
  end

endmodule

// File: hw/bmu_region_decode.sv
/*
 * bmu region decoder
 * picks tcip, the iahbl window or the biu default for one address
 */
`timescale 1ns/10ps

module bmu_region_decode (
  input  logic [bmu_bus_pkg::ADDR_W-1:0]   addr,
  input  logic [bmu_map_pkg::REGION_W-1:0] iahbl_base,
  input  logic [bmu_map_pkg::REGION_W-1:0] iahbl_mask,
  output bmu_map_pkg::target_e             target
);

  logic [bmu_map_pkg::REGION_W-1:0] region;
  logic [$bits(bmu_map_pkg::TCIP_NIBBLE)-1:0] top_nibble;
  logic tcip_hit;
  logic iahbl_hit;

  assign region     = addr[bmu_bus_pkg::ADDR_W-1 -: bmu_map_pkg::REGION_W];
  assign top_nibble = addr[bmu_bus_pkg::ADDR_W-1 -: $bits(bmu_map_pkg::TCIP_NIBBLE)];

  assign tcip_hit = (top_nibble == bmu_map_pkg::TCIP_NIBBLE);

  // only bits set in the mask take part in the compare
  assign iahbl_hit = (((region ^ iahbl_base) & iahbl_mask) == '0);

  // tcip wins over the iahbl window, biu takes the rest
  always_comb begin
    if (tcip_hit) begin
      target = bmu_map_pkg::TGT_TCIP;
    end else if (iahbl_hit) begin
      target = bmu_map_pkg::TGT_IAHBL;
    end else begin
      target = bmu_map_pkg::TGT_BIU;
    end
  end

endmodule

// File: hw/bmu_map_pkg.sv
/*
 * bus management unit address map
 * region widths, the tcip select value and the slave target codes
 */
package bmu_map_pkg;

  // upper address bits compared against the iahbl base/mask pins
  localparam int REGION_W = 12;

  // top address nibble of the tightly coupled IP space
  localparam logic [3:0] TCIP_NIBBLE = 4'hE;

  //==================================================
  // slave target codes
  //==================================================
  // deny has no slave behind it, completion is made locally
  typedef enum logic [2:0] {
    TGT_NONE  = 3'd0,
    TGT_TCIP  = 3'd1,
    TGT_IAHBL = 3'd2,
    TGT_BIU   = 3'd3,
    TGT_DENY  = 3'd4
  } target_e;

endpackage

// File: hw/bmu_bus_pkg.sv
/*
 * bus management unit bus types
 * payload widths plus the request and response structs shared by
 * the instruction bus, the data bus and every slave path
 */
package bmu_bus_pkg;

  //==================================================
  // payload widths
  //==================================================
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int PROT_W = 4;
  localparam int SIZE_W = 2;

  //==================================================
  // master requests
  //==================================================
  // instruction fetch, always a word read
  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] addr;
    logic [PROT_W-1:0] prot;
  } ibus_req_t;

  // load/store request
  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] addr;
    logic [PROT_W-1:0] prot;
    logic [SIZE_W-1:0] size;
    logic              write;
    logic [DATA_W-1:0] wdata;
  } dbus_req_t;

  //==================================================
  // response, same shape for masters and slaves
  //==================================================
  typedef struct packed {
    logic              grnt;
    logic              data_vld;
    logic [DATA_W-1:0] data;
    logic              trans_cmplt;
    logic              acc_err;
  } bus_rsp_t;

endpackage
